/* cpu_core.f */
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/instr_stream_if.sv
hdl/fetch_unit.sv
hdl/fetch_queue.sv
hdl/instr_decoder.sv
hdl/exec_pipeline.sv
hdl/cpu_core.sv
verif/cpu_core_tb.sv

/* hdl/cpu_core.sv */
`timescale 1ns/10ps

module cpu_core #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic        clk,
	input  logic        reset_n,
	input  logic [15:0] imem_data,
	input  logic [15:0] dmem_rdata,
	output logic        imem_read,
	output logic [15:0] imem_addr,
	output logic        dmem_read,
	output logic        dmem_write,
	output logic [15:0] dmem_addr,
	output logic [15:0] dmem_wdata,
	output logic [15:0] num_inst,
	output logic [15:0] output_port,
	output logic        is_halted
);
	logic        flush;
	logic [15:0] redirect_pc;

	instr_stream_if fetch_q ();
	instr_stream_if q_exec ();

	fetch_unit fetch_unit_inst (
		.clk         (clk),
		.reset_n     (reset_n),
		.flush       (flush),
		.redirect_pc (redirect_pc),
		.imem_data   (imem_data),
		.imem_read   (imem_read),
		.imem_addr   (imem_addr),
		.out         (fetch_q)
	);

	fetch_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) fetch_queue_inst (
		.clk     (clk),
		.reset_n (reset_n),
		.flush   (flush),
		.in      (fetch_q),
		.out     (q_exec)
	);

	exec_pipeline exec_pipeline_inst (
		.clk         (clk),
		.reset_n     (reset_n),
		.dmem_rdata  (dmem_rdata),
		.in          (q_exec),
		.flush       (flush),
		.redirect_pc (redirect_pc),
		.dmem_read   (dmem_read),
		.dmem_write  (dmem_write),
		.dmem_addr   (dmem_addr),
		.dmem_wdata  (dmem_wdata),
		.num_inst    (num_inst),
		.output_port (output_port),
		.is_halted   (is_halted)
	);

endmodule

/* hdl/exec_pipeline.sv */
`timescale 1ns/10ps

module exec_pipeline (
	input  logic        clk,
	input  logic        reset_n,
	input  logic [15:0] dmem_rdata,
	instr_stream_if.dst in,
	output logic        flush,
	output logic [15:0] redirect_pc,
	output logic        dmem_read,
	output logic        dmem_write,
	output logic [15:0] dmem_addr,
	output logic [15:0] dmem_wdata,
	output logic [15:0] num_inst,
	output logic [15:0] output_port,
	output logic        is_halted
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic [15:0] regs [4];

	instr_t      id_word;
	logic        id_valid;
	logic        halt_pending;
	logic        stall;
	logic        accept;
	logic        c_reg_write, c_mem_read, c_mem_write, c_mem_to_reg, c_alu_src;
	logic        c_pc_to_reg, c_wwd, c_halt, c_retire;
	logic        c_is_branch, c_is_jump, c_is_jump_reg;
	logic [1:0]  c_reg_dst;
	logic [2:0]  c_alu_op;
	logic [1:0]  id_rs, id_rt, id_dest;
	logic [15:0] id_rs_val, id_rt_val, id_imm, id_link;
	logic        is_rtype, uses_rs, uses_rt;
	logic        load_use, operand_wait, taken;

	logic        idex_reg_write, idex_mem_read, idex_mem_write, idex_mem_to_reg;
	logic        idex_pc_to_reg, idex_wwd, idex_retire, idex_halt, idex_alu_src;
	logic [2:0]  idex_alu_op;
	logic [1:0]  idex_rs, idex_rt, idex_dest;
	logic [15:0] idex_rs_val, idex_rt_val, idex_imm, idex_link;

	logic [1:0]  fwd_a, fwd_b;
	logic [15:0] ex_a, ex_b_reg, ex_b, alu_out, ex_result;

	logic        exmem_reg_write, exmem_mem_read, exmem_mem_write, exmem_mem_to_reg;
	logic        exmem_wwd, exmem_retire, exmem_halt;
	logic [1:0]  exmem_dest;
	logic [15:0] exmem_result, exmem_store, mem_value;

	logic        memwb_reg_write, memwb_wwd, memwb_retire, memwb_halt;
	logic [1:0]  memwb_dest;
	logic [15:0] memwb_result;

	// ID reads the queue head directly
	assign id_valid = in.valid && !halt_pending;
	assign id_word  = id_valid ? instr_t'(in.instr) : instr_t'(BUBBLE_WORD);
	assign id_rs    = id_word.r_fields.rs;
	assign id_rt    = id_word.r_fields.rt;

	instr_decoder decoder_inst (
		.instr       (id_word),
		.reg_write   (c_reg_write),
		.mem_read    (c_mem_read),
		.mem_write   (c_mem_write),
		.mem_to_reg  (c_mem_to_reg),
		.alu_src     (c_alu_src),
		.pc_to_reg   (c_pc_to_reg),
		.wwd         (c_wwd),
		.halt        (c_halt),
		.retire      (c_retire),
		.is_branch   (c_is_branch),
		.is_jump     (c_is_jump),
		.is_jump_reg (c_is_jump_reg),
		.reg_dst     (c_reg_dst),
		.alu_op      (c_alu_op)
	);

	// Register file with write-through from WB
	assign id_rs_val = (memwb_reg_write && memwb_dest == id_rs) ? memwb_result : regs[id_rs];
	assign id_rt_val = (memwb_reg_write && memwb_dest == id_rt) ? memwb_result : regs[id_rt];

	assign id_imm  = (id_word.i_fields.opcode == OP_ORI) ? {8'h00, id_word.i_fields.imm} :
		{{8{id_word.i_fields.imm[7]}}, id_word.i_fields.imm};
	assign id_link = in.pc + 16'd1;
	assign id_dest = (c_reg_dst == DST_RD) ? id_word.r_fields.rd :
		(c_reg_dst == DST_RT) ? id_rt : 2'd2;

	assign is_rtype = (id_word.r_fields.opcode == OP_RTYPE);
	assign uses_rs  = !(id_word.r_fields.opcode inside {OP_LHI, OP_JMP, OP_JAL}) &&
		!(is_rtype && id_word.r_fields.func == FN_HLT);
	assign uses_rt  = (is_rtype && id_word.r_fields.func inside {FN_ADD, FN_SUB, FN_AND, FN_ORR}) ||
		(id_word.r_fields.opcode inside {OP_SWD, OP_BNE, OP_BEQ});

	assign load_use = idex_mem_read && idex_reg_write &&
		((uses_rs && idex_dest == id_rs) || (uses_rt && idex_dest == id_rt));

	// Branch operands are read in ID without forwarding
	assign operand_wait = (c_is_branch || c_is_jump_reg) &&
		((uses_rs && ((idex_reg_write && idex_dest == id_rs) ||
			(exmem_reg_write && exmem_dest == id_rs))) ||
		(uses_rt && ((idex_reg_write && idex_dest == id_rt) ||
			(exmem_reg_write && exmem_dest == id_rt))));

	assign stall    = id_valid && (load_use || operand_wait);
	assign accept   = id_valid && !stall;
	assign in.ready = !stall && !halt_pending;

	always_comb begin
		case (id_word.i_fields.opcode)
			OP_BNE:  taken = (id_rs_val != id_rt_val);
			OP_BEQ:  taken = (id_rs_val == id_rt_val);
			OP_BGZ:  taken = ($signed(id_rs_val) > 0);
			OP_BLZ:  taken = ($signed(id_rs_val) < 0);
			default: taken = 1'b0;
		endcase
	end

	assign flush       = accept && ((c_is_branch && taken) || c_is_jump || c_is_jump_reg);
	assign redirect_pc = c_is_jump_reg ? id_rs_val :
		c_is_jump ? {in.pc[15:12], id_word.j_fields.target} : id_link + id_imm;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			halt_pending    <= 1'b0;
			idex_reg_write  <= 1'b0;
			idex_mem_read   <= 1'b0;
			idex_mem_write  <= 1'b0;
			idex_mem_to_reg <= 1'b0;
			idex_pc_to_reg  <= 1'b0;
			idex_wwd        <= 1'b0;
			idex_retire     <= 1'b0;
			idex_halt       <= 1'b0;
		end else begin
			if (accept && c_halt)
				halt_pending <= 1'b1;
			idex_reg_write  <= accept && c_reg_write;
			idex_mem_read   <= accept && c_mem_read;
			idex_mem_write  <= accept && c_mem_write;
			idex_mem_to_reg <= accept && c_mem_to_reg;
			idex_pc_to_reg  <= accept && c_pc_to_reg;
			idex_wwd        <= accept && c_wwd;
			idex_retire     <= accept && c_retire;
			idex_halt       <= accept && c_halt;
		end
	end

	always_ff @(posedge clk) begin
		idex_alu_src <= c_alu_src;
		idex_alu_op  <= c_alu_op;
		idex_rs      <= id_rs;
		idex_rt      <= id_rt;
		idex_dest    <= id_dest;
		idex_rs_val  <= id_rs_val;
		idex_rt_val  <= id_rt_val;
		idex_imm     <= id_imm;
		idex_link    <= id_link;
	end

	// EX forwarding, nearest writer first
	always_comb begin
		fwd_a = FWD_REGFILE;
		fwd_b = FWD_REGFILE;
		if (exmem_reg_write && exmem_dest == idex_rs)
			fwd_a = FWD_EXMEM;
		else if (memwb_reg_write && memwb_dest == idex_rs)
			fwd_a = FWD_MEMWB;
		if (exmem_reg_write && exmem_dest == idex_rt)
			fwd_b = FWD_EXMEM;
		else if (memwb_reg_write && memwb_dest == idex_rt)
			fwd_b = FWD_MEMWB;
	end

	// Load data reaches EX straight from the data memory
	assign mem_value = exmem_mem_to_reg ? dmem_rdata : exmem_result;

	assign ex_a = (fwd_a == FWD_EXMEM) ? mem_value :
		(fwd_a == FWD_MEMWB) ? memwb_result : idex_rs_val;
	assign ex_b_reg = (fwd_b == FWD_EXMEM) ? mem_value :
		(fwd_b == FWD_MEMWB) ? memwb_result : idex_rt_val;
	assign ex_b = idex_alu_src ? idex_imm : ex_b_reg;

	always_comb begin
		case (idex_alu_op)
			ALU_ADD:  alu_out = ex_a + ex_b;
			ALU_SUB:  alu_out = ex_a - ex_b;
			ALU_AND:  alu_out = ex_a & ex_b;
			ALU_OR:   alu_out = ex_a | ex_b;
			ALU_NOT:  alu_out = ~ex_a;
			ALU_LHI:  alu_out = {ex_b[7:0], 8'h00};
			default:  alu_out = ex_a;
		endcase
	end

	assign ex_result = idex_pc_to_reg ? idex_link : alu_out;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			exmem_reg_write  <= 1'b0;
			exmem_mem_read   <= 1'b0;
			exmem_mem_write  <= 1'b0;
			exmem_mem_to_reg <= 1'b0;
			exmem_wwd        <= 1'b0;
			exmem_retire     <= 1'b0;
			exmem_halt       <= 1'b0;
			memwb_reg_write  <= 1'b0;
			memwb_wwd        <= 1'b0;
			memwb_retire     <= 1'b0;
			memwb_halt       <= 1'b0;
		end else begin
			exmem_reg_write  <= idex_reg_write;
			exmem_mem_read   <= idex_mem_read;
			exmem_mem_write  <= idex_mem_write;
			exmem_mem_to_reg <= idex_mem_to_reg;
			exmem_wwd        <= idex_wwd;
			exmem_retire     <= idex_retire;
			exmem_halt       <= idex_halt;
			memwb_reg_write  <= exmem_reg_write;
			memwb_wwd        <= exmem_wwd;
			memwb_retire     <= exmem_retire;
			memwb_halt       <= exmem_halt;
		end
	end

	always_ff @(posedge clk) begin
		exmem_result <= ex_result;
		exmem_store  <= ex_b_reg;
		exmem_dest   <= idex_dest;
		memwb_result <= mem_value;
		memwb_dest   <= exmem_dest;
	end

	assign dmem_read  = exmem_mem_read;
	assign dmem_write = exmem_mem_write;
	assign dmem_addr  = exmem_result;
	assign dmem_wdata = exmem_store;

	// WB and retirement
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			regs        <= '{default: 16'h0000};
			num_inst    <= 16'h0000;
			output_port <= 16'h0000;
			is_halted   <= 1'b0;
		end else begin
			if (memwb_reg_write)
				regs[memwb_dest] <= memwb_result;
			if (memwb_retire)
				num_inst <= num_inst + 16'd1;
			if (memwb_wwd)
				output_port <= memwb_result;
			if (memwb_halt)
				is_halted <= 1'b1;
		end
	end

	assert property (@(posedge clk) disable iff (!reset_n)
		!(dmem_read && dmem_write));

	assert property (@(posedge clk) disable iff (!reset_n)
		stall |-> !flush);

endmodule

/* hdl/fetch_queue.sv */
`timescale 1ns/10ps

module fetch_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic        clk,
	input  logic        reset_n,
	input  logic        flush,
	instr_stream_if.dst in,
	instr_stream_if.src out
);
	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	logic [15:0]      pc_mem    [QUEUE_DEPTH];
	logic [15:0]      instr_mem [QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// Two free slots cover the request still in flight
	assign in.ready = (count <= CNT_W'(QUEUE_DEPTH - 2));
	assign push     = in.valid;

	assign out.valid = (count != '0);
	assign out.pc    = pc_mem[rd_ptr];
	assign out.instr = instr_mem[rd_ptr];
	assign pop       = out.valid && out.ready;

	always_ff @(posedge clk) begin
		if (!reset_n || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop)
				rd_ptr <= ptr_next(rd_ptr);
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			pc_mem[wr_ptr]    <= in.pc;
			instr_mem[wr_ptr] <= in.instr;
		end
	end

	assert property (@(posedge clk) disable iff (!reset_n)
		(count == CNT_W'(QUEUE_DEPTH)) |-> !in.valid);

	assert property (@(posedge clk) disable iff (!reset_n)
		(count == '0) |-> !pop);

endmodule

/* hdl/fetch_unit.sv */
`timescale 1ns/10ps

module fetch_unit (
	input  logic        clk,
	input  logic        reset_n,
	input  logic        flush,
	input  logic [15:0] redirect_pc,
	input  logic [15:0] imem_data,
	output logic        imem_read,
	output logic [15:0] imem_addr,
	instr_stream_if.src out
);
	import pipe_pkg::*;

	logic [15:0] pc;
	logic [15:0] req_pc;
	logic        running;
	logic        pending;
	logic        discard;

	// One request per cycle while the queue can absorb it
	assign imem_read = running && out.ready;
	assign imem_addr = pc;

	assign out.valid = pending && !discard;
	assign out.pc    = req_pc;
	assign out.instr = out.valid ? imem_data : BUBBLE_WORD;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc      <= RESET_PC;
			running <= 1'b0;
			pending <= 1'b0;
			discard <= 1'b0;
		end else begin
			running <= 1'b1;
			pending <= imem_read;
			// Word returning next cycle is from the old path
			discard <= flush;
			if (flush)
				pc <= redirect_pc;
			else if (imem_read)
				pc <= pc + 16'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (imem_read)
			req_pc <= pc;
	end

	assert property (@(posedge clk) disable iff (!reset_n)
		flush |=> !out.valid);

endmodule

/* hdl/instr_decoder.sv */
`timescale 1ns/10ps

module instr_decoder (
	input  isa_pkg::instr_t instr,
	output logic            reg_write,
	output logic            mem_read,
	output logic            mem_write,
	output logic            mem_to_reg,
	output logic            alu_src,
	output logic            pc_to_reg,
	output logic            wwd,
	output logic            halt,
	output logic            retire,
	output logic            is_branch,
	output logic            is_jump,
	output logic            is_jump_reg,
	output logic [1:0]      reg_dst,
	output logic [2:0]      alu_op
);
	import isa_pkg::*;
	import pipe_pkg::*;

	always_comb begin
		reg_write   = 1'b0;
		mem_read    = 1'b0;
		mem_write   = 1'b0;
		mem_to_reg  = 1'b0;
		alu_src     = 1'b0;
		pc_to_reg   = 1'b0;
		wwd         = 1'b0;
		halt        = 1'b0;
		retire      = 1'b1;
		is_branch   = 1'b0;
		is_jump     = 1'b0;
		is_jump_reg = 1'b0;
		reg_dst     = DST_RT;
		alu_op      = ALU_ADD;

		case (instr.r_fields.opcode)
			OP_ADI, OP_ORI, OP_LHI: begin
				reg_write = 1'b1;
				alu_src   = 1'b1;
				if (instr.i_fields.opcode == OP_ORI)
					alu_op = ALU_OR;
				else if (instr.i_fields.opcode == OP_LHI)
					alu_op = ALU_LHI;
			end
			OP_LWD: begin
				reg_write  = 1'b1;
				mem_read   = 1'b1;
				mem_to_reg = 1'b1;
				alu_src    = 1'b1;
			end
			OP_SWD: begin
				mem_write = 1'b1;
				alu_src   = 1'b1;
			end
			OP_BNE, OP_BEQ, OP_BGZ, OP_BLZ:
				is_branch = 1'b1;
			OP_JMP:
				is_jump = 1'b1;
			OP_JAL: begin
				is_jump   = 1'b1;
				reg_write = 1'b1;
				pc_to_reg = 1'b1;
				reg_dst   = DST_LINK;
			end
			OP_RTYPE: begin
				case (instr.r_fields.func)
					FN_ADD, FN_SUB, FN_AND, FN_ORR, FN_NOT: begin
						reg_write = 1'b1;
						reg_dst   = DST_RD;
						// Function codes 0 to 4 share the ALU encoding
						alu_op    = instr.r_fields.func[2:0];
					end
					FN_WWD: begin
						wwd    = 1'b1;
						alu_op = ALU_PASS;
					end
					FN_JPR:
						is_jump_reg = 1'b1;
					FN_JRL: begin
						is_jump_reg = 1'b1;
						reg_write   = 1'b1;
						pc_to_reg   = 1'b1;
						reg_dst     = DST_LINK;
					end
					FN_HLT:
						halt = 1'b1;
					default:
						retire = 1'b0;
				endcase
			end
			default:
				retire = 1'b0;
		endcase
	end

endmodule

/* hdl/instr_stream_if.sv */
`timescale 1ns/10ps

interface instr_stream_if;
	logic        valid;
	logic        ready;
	logic [15:0] pc;
	logic [15:0] instr;

	modport src (
		output valid,
		output pc,
		output instr,
		input  ready
	);

	modport dst (
		input  valid,
		input  pc,
		input  instr,
		output ready
	);
endinterface

/* hdl/isa_pkg.sv */
package isa_pkg;

	// Major opcodes
	localparam logic [3:0] OP_BNE   = 4'd0;
	localparam logic [3:0] OP_BEQ   = 4'd1;
	localparam logic [3:0] OP_BGZ   = 4'd2;
	localparam logic [3:0] OP_BLZ   = 4'd3;
	localparam logic [3:0] OP_ADI   = 4'd4;
	localparam logic [3:0] OP_ORI   = 4'd5;
	localparam logic [3:0] OP_LHI   = 4'd6;
	localparam logic [3:0] OP_LWD   = 4'd7;
	localparam logic [3:0] OP_SWD   = 4'd8;
	localparam logic [3:0] OP_JMP   = 4'd9;
	localparam logic [3:0] OP_JAL   = 4'd10;
	localparam logic [3:0] OP_RTYPE = 4'd15;

	// Function codes under OP_RTYPE
	localparam logic [5:0] FN_ADD = 6'd0;
	localparam logic [5:0] FN_SUB = 6'd1;
	localparam logic [5:0] FN_AND = 6'd2;
	localparam logic [5:0] FN_ORR = 6'd3;
	localparam logic [5:0] FN_NOT = 6'd4;
	localparam logic [5:0] FN_JPR = 6'd25;
	localparam logic [5:0] FN_JRL = 6'd26;
	localparam logic [5:0] FN_WWD = 6'd28;
	localparam logic [5:0] FN_HLT = 6'd29;

	// One instruction word, three field layouts
	typedef union packed {
		struct packed {
			logic [3:0] opcode;
			logic [1:0] rs;
			logic [1:0] rt;
			logic [1:0] rd;
			logic [5:0] func;
		} r_fields;
		struct packed {
			logic [3:0] opcode;
			logic [1:0] rs;
			logic [1:0] rt;
			logic [7:0] imm;
		} i_fields;
		struct packed {
			logic [3:0] opcode;
			logic [11:0] target;
		} j_fields;
	} instr_t;

endpackage

/* hdl/pipe_pkg.sv */
package pipe_pkg;

	localparam logic [15:0] RESET_PC = 16'h0000;

	// ADI r0, r0, 0 with its write suppressed by the pipeline
	localparam logic [15:0] BUBBLE_WORD = 16'h4000;

	// Operand source select in EX
	localparam logic [1:0] FWD_REGFILE = 2'b00;
	localparam logic [1:0] FWD_MEMWB   = 2'b01;
	localparam logic [1:0] FWD_EXMEM   = 2'b10;

	localparam logic [2:0] ALU_ADD  = 3'd0;
	localparam logic [2:0] ALU_SUB  = 3'd1;
	localparam logic [2:0] ALU_AND  = 3'd2;
	localparam logic [2:0] ALU_OR   = 3'd3;
	localparam logic [2:0] ALU_NOT  = 3'd4;
	localparam logic [2:0] ALU_PASS = 3'd5;
	localparam logic [2:0] ALU_LHI  = 3'd6;

	// Destination register select
	localparam logic [1:0] DST_RD   = 2'd0;
	localparam logic [1:0] DST_RT   = 2'd1;
	localparam logic [1:0] DST_LINK = 2'd2;

endpackage

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cpu_core_tb \
	-f cpu_core.f -o cpu_core_sim \
	&& ./obj_dir/cpu_core_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^PASS: all tests$" sim.log 2>/dev/null && echo "run_sim.sh: simulation passed" \
	|| { echo "run_sim.sh: simulation failed"; exit 1; }

/* verif/cpu_core_tb.sv */
`timescale 1ns/10ps

module cpu_core_tb;
	import isa_pkg::*;

	localparam int QUEUE_DEPTH  = 4;
	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 10;
	localparam int DRIVE_DELAY  = 2;

	logic        clk = 1'b0;
	logic        reset_n;
	logic [15:0] imem_data;
	logic [15:0] dmem_rdata;
	logic        imem_read;
	logic [15:0] imem_addr;
	logic        dmem_read;
	logic        dmem_write;
	logic [15:0] dmem_addr;
	logic [15:0] dmem_wdata;
	logic [15:0] num_inst;
	logic [15:0] output_port;
	logic        is_halted;

	logic [15:0] prog [$];
	logic [15:0] dmem [65536];
	logic [15:0] model_mem [65536];
	bit          prog_ready = 1'b0;

	// Reference model results, in retirement order
	bit          exp_ret_wwd [$];
	logic [15:0] exp_ret_val [$];
	logic [15:0] exp_wr_addr [$];
	logic [15:0] exp_wr_data [$];
	logic [15:0] exp_rd_addr [$];
	int          exp_count = 0;

	int          value_errors = 0;
	int          other_errors = 0;
	int          ret_idx = 0;
	int          wr_idx = 0;
	int          rd_idx = 0;
	int          halt_cycles = 0;
	logic [15:0] seen_inst = 16'h0000;
	logic [15:0] last_wwd = 16'h0000;

	logic        fetch_req;
	logic [15:0] fetch_addr;
	logic        store_en;
	logic [15:0] store_addr;
	logic [15:0] store_data;

	cpu_core #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) cpu_core_inst (
		.clk         (clk),
		.reset_n     (reset_n),
		.imem_data   (imem_data),
		.dmem_rdata  (dmem_rdata),
		.imem_read   (imem_read),
		.imem_addr   (imem_addr),
		.dmem_read   (dmem_read),
		.dmem_write  (dmem_write),
		.dmem_addr   (dmem_addr),
		.dmem_wdata  (dmem_wdata),
		.num_inst    (num_inst),
		.output_port (output_port),
		.is_halted   (is_halted)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [15:0] r_word(input logic [5:0] func, input logic [1:0] rs,
		input logic [1:0] rt, input logic [1:0] rd);
		instr_t w;
		w.r_fields.opcode = OP_RTYPE;
		w.r_fields.rs     = rs;
		w.r_fields.rt     = rt;
		w.r_fields.rd     = rd;
		w.r_fields.func   = func;
		return w;
	endfunction

	function automatic logic [15:0] i_word(input logic [3:0] op, input logic [1:0] rs,
		input logic [1:0] rt, input logic [7:0] imm);
		instr_t w;
		w.i_fields.opcode = op;
		w.i_fields.rs     = rs;
		w.i_fields.rt     = rt;
		w.i_fields.imm    = imm;
		return w;
	endfunction

	function automatic logic [15:0] j_word(input logic [3:0] op, input logic [11:0] target);
		instr_t w;
		w.j_fields.opcode = op;
		w.j_fields.target = target;
		return w;
	endfunction

	function automatic logic [15:0] sign_ext(input logic [7:0] v);
		return {{8{v[7]}}, v};
	endfunction

	// Past the end of the image the memory reads as HLT
	function automatic logic [15:0] instr_at(input logic [15:0] addr);
		if (int'(addr) < prog.size())
			return prog[addr];
		return r_word(FN_HLT, 2'd0, 2'd0, 2'd0);
	endfunction

	task automatic build_program();
		logic [7:0] imm [7];
		foreach (imm[k])
			imm[k] = 8'($urandom);
		prog.delete();
		prog.push_back(i_word(OP_LHI, 2'd0, 2'd1, imm[0]));
		prog.push_back(i_word(OP_ORI, 2'd1, 2'd1, imm[1]));
		prog.push_back(i_word(OP_ADI, 2'd1, 2'd2, imm[2]));
		prog.push_back(r_word(FN_ADD, 2'd1, 2'd2, 2'd3));
		prog.push_back(r_word(FN_SUB, 2'd3, 2'd1, 2'd0));
		prog.push_back(r_word(FN_AND, 2'd0, 2'd3, 2'd2));
		prog.push_back(r_word(FN_ORR, 2'd2, 2'd0, 2'd1));
		prog.push_back(r_word(FN_NOT, 2'd1, 2'd0, 2'd3));
		prog.push_back(r_word(FN_WWD, 2'd0, 2'd0, 2'd0));
		prog.push_back(r_word(FN_WWD, 2'd3, 2'd0, 2'd0));
		// Store, reload, then use the loaded value at once
		prog.push_back(i_word(OP_SWD, 2'd2, 2'd3, imm[3]));
		prog.push_back(i_word(OP_LWD, 2'd2, 2'd0, imm[3]));
		prog.push_back(r_word(FN_ADD, 2'd0, 2'd0, 2'd1));
		prog.push_back(r_word(FN_WWD, 2'd1, 2'd0, 2'd0));
		prog.push_back(i_word(OP_LWD, 2'd1, 2'd3, imm[4]));
		prog.push_back(r_word(FN_WWD, 2'd3, 2'd0, 2'd0));
		prog.push_back(i_word(OP_SWD, 2'd3, 2'd1, imm[5]));
		// Branches, taken and not taken
		prog.push_back(i_word(OP_BNE, 2'd0, 2'd0, 8'd2));
		prog.push_back(r_word(FN_WWD, 2'd0, 2'd0, 2'd0));
		prog.push_back(i_word(OP_BEQ, 2'd2, 2'd2, 8'd2));
		prog.push_back(r_word(FN_WWD, 2'd1, 2'd0, 2'd0));
		prog.push_back(i_word(OP_SWD, 2'd0, 2'd1, 8'd0));
		prog.push_back(i_word(OP_LHI, 2'd0, 2'd3, 8'h40));
		prog.push_back(i_word(OP_BGZ, 2'd3, 2'd0, 8'd1));
		prog.push_back(r_word(FN_WWD, 2'd3, 2'd0, 2'd0));
		prog.push_back(i_word(OP_BLZ, 2'd3, 2'd0, 8'd1));
		prog.push_back(r_word(FN_NOT, 2'd3, 2'd0, 2'd3));
		prog.push_back(i_word(OP_BLZ, 2'd3, 2'd0, 8'd1));
		prog.push_back(i_word(OP_SWD, 2'd3, 2'd3, 8'd0));
		prog.push_back(i_word(OP_BGZ, 2'd3, 2'd0, 8'd1));
		// Jumps with link values seen through WWD
		prog.push_back(j_word(OP_JAL, 12'd33));
		prog.push_back(r_word(FN_WWD, 2'd0, 2'd0, 2'd0));
		prog.push_back(r_word(FN_HLT, 2'd0, 2'd0, 2'd0));
		prog.push_back(r_word(FN_WWD, 2'd2, 2'd0, 2'd0));
		prog.push_back(i_word(OP_LHI, 2'd0, 2'd1, 8'd0));
		prog.push_back(i_word(OP_ORI, 2'd1, 2'd1, 8'd39));
		prog.push_back(r_word(FN_JRL, 2'd1, 2'd0, 2'd0));
		prog.push_back(r_word(FN_WWD, 2'd1, 2'd0, 2'd0));
		prog.push_back(r_word(FN_HLT, 2'd0, 2'd0, 2'd0));
		prog.push_back(r_word(FN_WWD, 2'd2, 2'd0, 2'd0));
		prog.push_back(j_word(OP_JMP, 12'd42));
		prog.push_back(r_word(FN_WWD, 2'd0, 2'd0, 2'd0));
		prog.push_back(i_word(OP_ADI, 2'd0, 2'd0, imm[6]));
		prog.push_back(r_word(FN_WWD, 2'd0, 2'd0, 2'd0));
		prog.push_back(r_word(FN_HLT, 2'd0, 2'd0, 2'd0));
	endtask

	// ISA interpreter, one instruction per step
	task automatic run_model();
		logic [15:0] r [4];
		logic [15:0] pc, nxt, a, b, ea, wwd_val;
		logic [7:0]  imm;
		logic [1:0]  rt, rd;
		instr_t      w;
		bit          wwd_flag;
		bit          done;
		int          steps;
		r = '{default: 16'h0000};
		pc = 16'h0000;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 1000) begin
			w = instr_at(pc);
			nxt = pc + 16'd1;
			a = r[w.r_fields.rs];
			b = r[w.r_fields.rt];
			rt = w.i_fields.rt;
			rd = w.r_fields.rd;
			imm = w.i_fields.imm;
			ea = a + sign_ext(imm);
			wwd_flag = 1'b0;
			wwd_val = 16'h0000;
			case (w.r_fields.opcode)
				OP_ADI: r[rt] = a + sign_ext(imm);
				OP_ORI: r[rt] = a | {8'h00, imm};
				OP_LHI: r[rt] = {imm, 8'h00};
				OP_LWD: begin
					r[rt] = model_mem[ea];
					exp_rd_addr.push_back(ea);
				end
				OP_SWD: begin
					model_mem[ea] = b;
					exp_wr_addr.push_back(ea);
					exp_wr_data.push_back(b);
				end
				OP_BNE: if (a != b) nxt = nxt + sign_ext(imm);
				OP_BEQ: if (a == b) nxt = nxt + sign_ext(imm);
				OP_BGZ: if (!a[15] && a != 16'h0000) nxt = nxt + sign_ext(imm);
				OP_BLZ: if (a[15]) nxt = nxt + sign_ext(imm);
				OP_JMP: nxt = {pc[15:12], w.j_fields.target};
				OP_JAL: begin
					r[2] = nxt;
					nxt = {pc[15:12], w.j_fields.target};
				end
				default: begin
					case (w.r_fields.func)
						FN_ADD: r[rd] = a + b;
						FN_SUB: r[rd] = a - b;
						FN_AND: r[rd] = a & b;
						FN_ORR: r[rd] = a | b;
						FN_NOT: r[rd] = ~a;
						FN_WWD: begin
							wwd_flag = 1'b1;
							wwd_val = a;
						end
						FN_JPR: nxt = a;
						FN_JRL: begin
							r[2] = nxt;
							nxt = a;
						end
						default: done = 1'b1;
					endcase
				end
			endcase
			exp_ret_wwd.push_back(wwd_flag);
			exp_ret_val.push_back(wwd_val);
			exp_count++;
			pc = nxt;
			steps++;
		end
		if (!done) begin
			other_errors++;
			$display("ERROR: reference model never reached HLT");
		end
	endtask

	assign dmem_rdata = dmem[dmem_addr];

	// Memory models, answering a fixed delay after the edge
	always @(posedge clk) begin
		fetch_req  = imem_read;
		fetch_addr = imem_addr;
		store_en   = dmem_write && reset_n;
		store_addr = dmem_addr;
		store_data = dmem_wdata;
		#DRIVE_DELAY;
		if (fetch_req === 1'b1)
			imem_data = instr_at(fetch_addr);
		if (store_en === 1'b1)
			dmem[store_addr] = store_data;
	end

	// Retirement, load and store checks against the model
	always @(negedge clk) begin
		if (reset_n) begin
			if (num_inst != seen_inst) begin
				assert (num_inst == seen_inst + 16'd1) else begin
					other_errors++;
					$display("ERROR: num_inst advanced by more than one in a cycle");
				end
				assert (ret_idx < exp_ret_wwd.size()) else begin
					other_errors++;
					$display("ERROR: core retired more instructions than the program executes");
				end
				if (ret_idx < exp_ret_wwd.size()) begin
					if (exp_ret_wwd[ret_idx])
						last_wwd = exp_ret_val[ret_idx];
					assert (output_port == last_wwd) else begin
						value_errors++;
						$display("FAIL output_port: expected 0x%h, got 0x%h", last_wwd, output_port);
					end
				end
				ret_idx++;
				seen_inst = num_inst;
			end
			if (dmem_read) begin
				assert (rd_idx < exp_rd_addr.size()) else begin
					other_errors++;
					$display("ERROR: data memory read that the program never makes");
				end
				if (rd_idx < exp_rd_addr.size()) begin
					assert (dmem_addr == exp_rd_addr[rd_idx]) else begin
						value_errors++;
						$display("FAIL dmem_addr: expected 0x%h, got 0x%h",
							exp_rd_addr[rd_idx], dmem_addr);
					end
				end
				rd_idx++;
			end
			if (dmem_write) begin
				assert (wr_idx < exp_wr_addr.size()) else begin
					other_errors++;
					$display("ERROR: data memory write that the program never makes");
				end
				if (wr_idx < exp_wr_addr.size()) begin
					assert (dmem_addr == exp_wr_addr[wr_idx]) else begin
						value_errors++;
						$display("FAIL dmem_addr: expected 0x%h, got 0x%h",
							exp_wr_addr[wr_idx], dmem_addr);
					end
					assert (dmem_wdata == exp_wr_data[wr_idx]) else begin
						value_errors++;
						$display("FAIL dmem_wdata: expected 0x%h, got 0x%h",
							exp_wr_data[wr_idx], dmem_wdata);
					end
				end
				wr_idx++;
			end
			if (is_halted)
				halt_cycles++;
			assert (!(imem_read && halt_cycles > QUEUE_DEPTH)) else begin
				other_errors++;
				$display("ERROR: instruction fetch continued long after halt");
			end
		end
	end

	// A request needs two free queue slots
	assert property (@(posedge clk) disable iff (!reset_n)
		imem_read |-> (QUEUE_DEPTH - int'(cpu_core_inst.fetch_queue_inst.count) >= 2))
		else begin
			other_errors++;
			$display("ERROR: instruction fetch issued while the fetch queue had no room");
		end

	assert property (@(posedge clk) disable iff (!reset_n)
		is_halted |=> is_halted)
		else begin
			value_errors++;
			$display("FAIL is_halted: expected 0x1, got 0x%h", is_halted);
		end

	initial begin
		reset_n = 1'b0;
		imem_data = 16'h0000;
		void'($urandom(61));
		build_program();
		for (int i = 0; i < 65536; i++) begin
			dmem[i] = 16'($urandom);
			model_mem[i] = dmem[i];
		end
		run_model();
		prog_ready = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY reset_n = 1'b1;
		while (is_halted !== 1'b1)
			@(posedge clk);
		repeat (QUEUE_DEPTH + 4) @(posedge clk);
		#DRIVE_DELAY;
		assert (num_inst == 16'(exp_count)) else begin
			value_errors++;
			$display("FAIL num_inst: expected 0x%h, got 0x%h", 16'(exp_count), num_inst);
		end
		assert (wr_idx == exp_wr_addr.size()) else begin
			other_errors++;
			$display("ERROR: core made %0d data writes, program makes %0d",
				wr_idx, exp_wr_addr.size());
		end
		assert (rd_idx == exp_rd_addr.size()) else begin
			other_errors++;
			$display("ERROR: core made %0d data reads, program makes %0d",
				rd_idx, exp_rd_addr.size());
		end
		$display("Error count: %0d value mismatches, %0d other failures",
			value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// Watchdog sized from the program length
	initial begin
		wait (prog_ready);
		#((RESET_CYCLES + 20 * prog.size()) * CLK_PERIOD);
		other_errors++;
		$display("ERROR: timeout, the core never halted");
		$display("Error count: %0d value mismatches, %0d other failures",
			value_errors, other_errors);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule
